//--- design/intra4x4_pkg.sv
package intra4x4_pkg;

    typedef logic        [7:0]  pixel_t;
    typedef logic signed [14:0] coeff_t;
    typedef logic signed [8:0]  res_t;     // Source minus prediction.
    typedef logic signed [15:0] recon_t;   // Inverse transform output.

    // Blocks are indexed [row][col].
    typedef pixel_t [3:0][3:0] pix_blk_t;
    typedef coeff_t [3:0][3:0] coeff_blk_t;
    typedef res_t   [3:0][3:0] res_blk_t;
    typedef recon_t [3:0][3:0] recon_res_blk_t;
    typedef pixel_t [3:0]      nbr_row_t;

    typedef struct packed {
        pix_blk_t src;
        nbr_row_t top;
        nbr_row_t left;
        logic     top_valid;
        logic     left_valid;
    } blk_in_t;

    typedef struct packed {
        coeff_blk_t coeff;
        pix_blk_t   recon;
    } blk_out_t;

    // Forward scaling, rows by QP mod 6, columns by position class.
    localparam logic [13:0] quant_mf [6][3] = '{
        '{14'd13107, 14'd5243, 14'd8066},
        '{14'd11916, 14'd4660, 14'd7490},
        '{14'd10082, 14'd4194, 14'd6554},
        '{14'd9362,  14'd3647, 14'd5825},
        '{14'd8192,  14'd3355, 14'd5243},
        '{14'd7282,  14'd2893, 14'd4559}
    };

    localparam logic [4:0] dequant_v [6][3] = '{
        '{5'd10, 5'd16, 5'd13},
        '{5'd11, 5'd18, 5'd14},
        '{5'd13, 5'd20, 5'd16},
        '{5'd14, 5'd23, 5'd18},
        '{5'd16, 5'd25, 5'd20},
        '{5'd18, 5'd29, 5'd23}
    };

    // 0 for even/even, 1 for odd/odd, 2 otherwise.
    function automatic logic [1:0] pos_class(input int row, input int col);
        if (row % 2 == 0 && col % 2 == 0)
            return 2'd0;
        else if (row % 2 == 1 && col % 2 == 1)
            return 2'd1;
        else
            return 2'd2;
    endfunction

endpackage

//--- design/stream_skid.sv
`timescale 1ns/1ns

module stream_skid #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    payload_t main_q;
    payload_t spare_q;
    logic     main_v;
    logic     spare_v;
    logic     in_fire;
    logic     out_fire;

    assign in_ready_o  = !spare_v;   // Ready comes straight from a flop.
    assign out_valid_o = main_v;
    assign out_data_o  = main_q;

    assign in_fire  = in_valid_i && in_ready_o;
    assign out_fire = main_v && out_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            main_v  <= 1'b0;
            spare_v <= 1'b0;
        end else if (spare_v) begin
            if (out_fire)
                spare_v <= 1'b0;     // Spare moves up, main stays valid.
        end else if (in_fire) begin
            if (main_v && !out_fire)
                spare_v <= 1'b1;
            main_v <= 1'b1;
        end else if (out_fire) begin
            main_v <= 1'b0;
        end
    end

    // Spare is only written when the output stalls during an input transfer.
    always_ff @(posedge clk) begin
        if (spare_v) begin
            if (out_fire)
                main_q <= spare_q;
        end else if (in_fire) begin
            if (main_v && !out_fire)
                spare_q <= in_data_i;
            else
                main_q <= in_data_i;
        end
    end

endmodule

//--- design/intra_dc_pred.sv
`timescale 1ns/1ns

module intra_dc_pred (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_i,
    input  intra4x4_pkg::nbr_row_t top_i,
    input  intra4x4_pkg::nbr_row_t left_i,
    input  logic                   top_valid_i,
    input  logic                   left_valid_i,
    output intra4x4_pkg::pixel_t   pred_o
);
    import intra4x4_pkg::*;

    logic [9:0]  top_rnd;
    logic [9:0]  left_rnd;
    logic [10:0] all_rnd;
    pixel_t      dc_val;

    // Rounded sums, the shift is taken by the bit select below.
    always_comb begin
        top_rnd  = top_i[0] + top_i[1] + top_i[2] + top_i[3] + 10'd2;
        left_rnd = left_i[0] + left_i[1] + left_i[2] + left_i[3] + 10'd2;
        all_rnd  = top_i[0] + top_i[1] + top_i[2] + top_i[3]
                 + left_i[0] + left_i[1] + left_i[2] + left_i[3] + 11'd4;
    end

    always_comb begin
        case ({top_valid_i, left_valid_i})
            2'b00:   dc_val = 8'd128;
            2'b10:   dc_val = top_rnd[9:2];
            2'b01:   dc_val = left_rnd[9:2];
            default: dc_val = all_rnd[10:3];
        endcase
    end

    // One value covers the whole block.
    always_ff @(posedge clk) begin
        if (rst)
            pred_o <= 8'd0;
        else if (load_i)
            pred_o <= dc_val;
    end

endmodule

//--- design/fwd_transform_quant.sv
`timescale 1ns/1ns

module fwd_transform_quant #(
    parameter int QP = 27
) (
    input  intra4x4_pkg::res_blk_t   res_i,
    output intra4x4_pkg::coeff_blk_t coeff_o
);
    import intra4x4_pkg::*;

    localparam int QP_PER = QP / 6;
    localparam int QP_REM = QP % 6;
    localparam int QBITS  = 15 + QP_PER;
    localparam int F_ROUND = (1 << QBITS) / 3;   // Intra rounding offset.

    typedef logic signed [15:0] t16_t;
    typedef t16_t [3:0] vec4_t;

    vec4_t [3:0] h_rows;   // After the row pass, [row][col].
    vec4_t [3:0] w_blk;    // Transform coefficients, [row][col].

    // Core transform butterfly on one line.
    function automatic vec4_t core_1d(input vec4_t x);
        t16_t s03;
        t16_t s12;
        t16_t d12;
        t16_t d03;
        vec4_t y;
        s03 = x[0] + x[3];
        s12 = x[1] + x[2];
        d12 = x[1] - x[2];
        d03 = x[0] - x[3];
        y[0] = s03 + s12;
        y[1] = (d03 <<< 1) + d12;
        y[2] = s03 - s12;
        y[3] = d03 - (d12 <<< 1);
        return y;
    endfunction

    always_comb begin
        vec4_t line;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++)
                line[c] = res_i[r][c];
            h_rows[r] = core_1d(line);
        end
    end

    always_comb begin
        vec4_t line;
        vec4_t outv;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++)
                line[r] = h_rows[r][c];
            outv = core_1d(line);
            for (int r = 0; r < 4; r++)
                w_blk[r][c] = outv[r];
        end
    end

    // Quantize on the magnitude, then put the sign back.
    always_comb begin
        t16_t        w;
        t16_t        abs_w;
        logic [31:0] mag;
        logic [31:0] lvl;
        coeff_t      lvl15;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                w     = w_blk[r][c];
                abs_w = w[15] ? -w : w;
                mag   = {16'd0, abs_w};
                lvl   = (mag * quant_mf[QP_REM][pos_class(r, c)] + F_ROUND) >> QBITS;
                lvl15 = coeff_t'(lvl[14:0]);
                coeff_o[r][c] = w[15] ? -lvl15 : lvl15;
            end
        end
    end

endmodule

//--- design/inv_transform_dequant.sv
`timescale 1ns/1ns

module inv_transform_dequant #(
    parameter int QP = 27
) (
    input  intra4x4_pkg::coeff_blk_t     coeff_i,
    output intra4x4_pkg::recon_res_blk_t res_o
);
    import intra4x4_pkg::*;

    localparam int QP_PER = QP / 6;
    localparam int QP_REM = QP % 6;

    typedef logic signed [31:0] t32_t;
    typedef t32_t [3:0] vec4_t;

    vec4_t [3:0] d_blk;    // Dequantized levels, [row][col].
    vec4_t [3:0] h_rows;   // After the row pass.

    // Inverse butterfly, odd inputs enter at half weight.
    function automatic vec4_t inv_1d(input vec4_t x);
        t32_t e0;
        t32_t e1;
        t32_t e2;
        t32_t e3;
        vec4_t y;
        e0 = x[0] + x[2];
        e1 = x[0] - x[2];
        e2 = (x[1] >>> 1) - x[3];
        e3 = x[1] + (x[3] >>> 1);
        y[0] = e0 + e3;
        y[1] = e1 + e2;
        y[2] = e1 - e2;
        y[3] = e0 - e3;
        return y;
    endfunction

    always_comb begin
        t32_t lvl;
        t32_t scale;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                lvl   = coeff_i[r][c];
                scale = t32_t'(dequant_v[QP_REM][pos_class(r, c)]);
                d_blk[r][c] = (lvl * scale) <<< QP_PER;
            end
        end
    end

    always_comb begin
        for (int r = 0; r < 4; r++)
            h_rows[r] = inv_1d(d_blk[r]);
    end

    // Column pass, then round and scale down by 64.
    always_comb begin
        vec4_t line;
        vec4_t outv;
        t32_t  rnd;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++)
                line[r] = h_rows[r][c];
            outv = inv_1d(line);
            for (int r = 0; r < 4; r++) begin
                rnd = (outv[r] + 32) >>> 6;
                res_o[r][c] = recon_t'(rnd[15:0]);
            end
        end
    end

endmodule

//--- design/intra_4x4_pe.sv
`timescale 1ns/1ns

module intra_4x4_pe #(
    parameter int QP = 27
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  intra4x4_pkg::blk_in_t  in_data_i,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output intra4x4_pkg::blk_out_t out_data_o
);
    import intra4x4_pkg::*;

    localparam int S_IDLE  = 0;
    localparam int S_PRED  = 1;
    localparam int S_RES   = 2;
    localparam int S_COEF  = 3;
    localparam int S_INV   = 4;
    localparam int S_RECON = 5;
    localparam int S_HOLD  = 6;
    localparam int S_NUM   = 7;

    logic [S_NUM-1:0] state;
    logic [S_NUM-1:0] state_nxt;

    blk_in_t        blk_q;
    pixel_t         pred;
    res_blk_t       res_q;
    coeff_blk_t     coeff_c;
    coeff_blk_t     coeff_q;
    recon_res_blk_t inv_c;
    recon_res_blk_t inv_q;
    pix_blk_t       recon_c;
    pix_blk_t       recon_q;

    assign in_ready_o  = state[S_IDLE];
    assign out_valid_o = state[S_HOLD];
    assign out_data_o  = '{coeff: coeff_q, recon: recon_q};

    // Every stage but idle and hold lasts exactly one cycle.
    always_comb begin
        state_nxt          = '0;
        state_nxt[S_IDLE]  = (state[S_IDLE] && !in_valid_i) || (state[S_HOLD] && out_ready_i);
        state_nxt[S_PRED]  = state[S_IDLE] && in_valid_i;
        state_nxt[S_RES]   = state[S_PRED];
        state_nxt[S_COEF]  = state[S_RES];
        state_nxt[S_INV]   = state[S_COEF];
        state_nxt[S_RECON] = state[S_INV];
        state_nxt[S_HOLD]  = state[S_RECON] || (state[S_HOLD] && !out_ready_i);
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= S_NUM'(1) << S_IDLE;
        else
            state <= state_nxt;
    end

    intra_dc_pred u_dc_pred (
        .clk          (clk),
        .rst          (rst),
        .load_i       (state[S_PRED]),
        .top_i        (blk_q.top),
        .left_i       (blk_q.left),
        .top_valid_i  (blk_q.top_valid),
        .left_valid_i (blk_q.left_valid),
        .pred_o       (pred)
    );

    fwd_transform_quant #(.QP(QP)) u_fwd (.res_i(res_q), .coeff_o(coeff_c));

    inv_transform_dequant #(.QP(QP)) u_inv (.coeff_i(coeff_q), .res_o(inv_c));

    // Prediction plus inverse residual, clipped to a pixel.
    always_comb begin
        logic signed [16:0] sum;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                sum = $signed({9'd0, pred}) + inv_q[r][c];
                if (sum < 0)
                    recon_c[r][c] = 8'd0;
                else if (sum > 17'sd255)
                    recon_c[r][c] = 8'd255;
                else
                    recon_c[r][c] = sum[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o)
            blk_q <= in_data_i;
        if (state[S_RES]) begin
            for (int r = 0; r < 4; r++)
                for (int c = 0; c < 4; c++)
                    res_q[r][c] <= res_t'({1'b0, blk_q.src[r][c]} - {1'b0, pred});
        end
        if (state[S_COEF])
            coeff_q <= coeff_c;
        if (state[S_INV])
            inv_q <= inv_c;
        if (state[S_RECON])
            recon_q <= recon_c;   // Output payload, valid from the hold stage.
    end

endmodule

//--- design/intra_4x4_top.sv
`timescale 1ns/1ns

module intra_4x4_top #(
    parameter int QP = 27
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  intra4x4_pkg::blk_in_t  in_data_i,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output intra4x4_pkg::blk_out_t out_data_o
);
    import intra4x4_pkg::*;

    logic     pe_in_valid;
    logic     pe_in_ready;
    blk_in_t  pe_in_data;
    logic     pe_out_valid;
    logic     pe_out_ready;
    blk_out_t pe_out_data;

    stream_skid #(.payload_t(blk_in_t)) u_in_skid (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (in_data_i),
        .out_valid_o (pe_in_valid),
        .out_ready_i (pe_in_ready),
        .out_data_o  (pe_in_data)
    );

    intra_4x4_pe #(.QP(QP)) u_pe (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (pe_in_valid),
        .in_ready_o  (pe_in_ready),
        .in_data_i   (pe_in_data),
        .out_valid_o (pe_out_valid),
        .out_ready_i (pe_out_ready),
        .out_data_o  (pe_out_data)
    );

    stream_skid #(.payload_t(blk_out_t)) u_out_skid (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (pe_out_valid),
        .in_ready_o  (pe_out_ready),
        .in_data_i   (pe_out_data),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o)
    );

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;   // 10 ns period.
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

//--- sim/tb_intra_4x4.sv
`timescale 1ns/1ns

module tb_intra_4x4;
    import intra4x4_pkg::*;

    localparam int QP         = 27;
    localparam int QP_PER     = QP / 6;
    localparam int QP_REM     = QP % 6;
    localparam int QBITS      = 15 + QP_PER;
    localparam int N_RANDOM   = 180;
    localparam int N_TOTAL    = 200;
    localparam int MAX_CYCLES = N_TOTAL * 40 + 200;

    localparam int MF [6][3] = '{'{13107, 5243, 8066}, '{11916, 4660, 7490},
                                 '{10082, 4194, 6554}, '{9362, 3647, 5825},
                                 '{8192, 3355, 5243}, '{7282, 2893, 4559}};
    localparam int DQ [6][3] = '{'{10, 16, 13}, '{11, 18, 14}, '{13, 20, 16},
                                 '{14, 23, 18}, '{16, 25, 20}, '{18, 29, 23}};
    localparam int CF [4][4] = '{'{1, 1, 1, 1}, '{2, 1, -1, -2},
                                 '{1, -1, -1, 1}, '{1, -2, 2, -1}};

    typedef struct packed {
        blk_out_t           out;
        logic [7:0]         dc;
        logic signed [15:0] inv00;      // Inverse residual at [0][0].
        logic [1:0]         dc_case;
        logic               flat;
        logic               clip_lo;
        logic               clip_hi;
        logic [31:0]        acc_cycle;
    } exp_t;

    logic     clk;
    logic     rst;
    logic     in_valid;
    logic     in_ready;
    blk_in_t  in_data;
    logic     out_valid;
    logic     out_ready;
    blk_out_t out_data;

    exp_t        expq [$];
    logic [31:0] lcg_state = 32'h3a13;
    int          cycles = 0;
    int          issued = 0;
    int          accepted = 0;
    int          received = 0;
    int          target = N_RANDOM;
    bit          burst = 1'b0;
    bit          skid_full = 1'b0;
    int          last_acc = 0;
    int          checks = 0;
    int          errs [6] = '{default: 0};   // Reset, dc, coeff, recon, order, burst.
    int          case_count [4] = '{default: 0};
    int          flat_count = 0;
    int          clip_lo_count = 0;
    int          clip_hi_count = 0;

    tb_clk_gen #(.RESET_CYCLES(8)) u_clk_gen (.clk_o(clk), .rst_o(rst));

    intra_4x4_top #(.QP(QP)) dut_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .in_data_i   (in_data),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .out_data_o  (out_data)
    );

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:16]);   // Low bits of an LCG repeat too soon.
    endfunction

    function automatic int class_of(input int r, input int c);
        if (r % 2 == 0 && c % 2 == 0)
            return 0;
        if (r % 2 == 1 && c % 2 == 1)
            return 1;
        return 2;
    endfunction

    function automatic int clip_pixel(input int v);
        return (v < 0) ? 0 : ((v > 255) ? 255 : v);
    endfunction

    function automatic blk_in_t random_block();
        blk_in_t b;
        int      kind;
        int      level;
        kind  = next_rand() % 8;
        level = (kind == 0) ? 0 : ((kind == 1) ? 255 : next_rand() % 256);
        for (int r = 0; r < 4; r++)
            for (int c = 0; c < 4; c++)
                b.src[r][c] = (kind < 3) ? pixel_t'(level) : pixel_t'(next_rand());
        for (int i = 0; i < 4; i++) begin
            b.top[i]  = pixel_t'(next_rand());
            b.left[i] = pixel_t'(next_rand());
        end
        b.top_valid  = next_rand() % 2;
        b.left_valid = next_rand() % 2;
        return b;
    endfunction

    // DC rule, residual, Cf*X*CfT, quantization, dequantization, inverse and clipping.
    function automatic exp_t model_block(input blk_in_t b, input int cycle);
        exp_t e;
        int   st;
        int   sl;
        int   dc;
        int   w;
        int   lvl;
        int   pix;
        int   x [4][4];
        int   t [4][4];
        int   d [4][4];
        int   h [4][4];
        int   o [4][4];
        int   a [4];
        int   y [4];
        e  = '0;
        st = int'(b.top[0]) + b.top[1] + b.top[2] + b.top[3];
        sl = int'(b.left[0]) + b.left[1] + b.left[2] + b.left[3];
        case ({b.top_valid, b.left_valid})
            2'b00:   dc = 128;
            2'b10:   dc = (st + 2) >> 2;
            2'b01:   dc = (sl + 2) >> 2;
            default: dc = (st + sl + 4) >> 3;
        endcase
        e.dc      = dc;
        e.dc_case = {b.top_valid, b.left_valid};
        e.flat    = 1'b1;
        for (int r = 0; r < 4; r++)
            for (int c = 0; c < 4; c++) begin
                x[r][c] = int'(b.src[r][c]) - dc;
                if (b.src[r][c] != b.src[0][0])
                    e.flat = 1'b0;
            end
        for (int r = 0; r < 4; r++)
            for (int c = 0; c < 4; c++) begin
                t[r][c] = 0;
                for (int k = 0; k < 4; k++)
                    t[r][c] += CF[r][k] * x[k][c];
            end
        for (int r = 0; r < 4; r++)
            for (int c = 0; c < 4; c++) begin
                w = 0;
                for (int k = 0; k < 4; k++)
                    w += t[r][k] * CF[c][k];
                lvl = ((w < 0 ? -w : w) * MF[QP_REM][class_of(r, c)] + (1 << QBITS) / 3)
                      >> QBITS;
                if (w < 0)
                    lvl = -lvl;
                e.out.coeff[r][c] = coeff_t'(lvl);
                d[r][c] = (lvl * DQ[QP_REM][class_of(r, c)]) <<< QP_PER;
            end
        for (int p = 0; p < 2; p++)   // Rows first, then columns.
            for (int i = 0; i < 4; i++) begin
                for (int k = 0; k < 4; k++)
                    a[k] = (p == 0) ? d[i][k] : h[k][i];
                y[0] = (a[0] + a[2]) + (a[1] + (a[3] >>> 1));
                y[1] = (a[0] - a[2]) + ((a[1] >>> 1) - a[3]);
                y[2] = (a[0] - a[2]) - ((a[1] >>> 1) - a[3]);
                y[3] = (a[0] + a[2]) - (a[1] + (a[3] >>> 1));
                for (int k = 0; k < 4; k++)
                    if (p == 0)
                        h[i][k] = y[k];
                    else
                        o[k][i] = (y[k] + 32) >>> 6;
            end
        e.inv00 = 16'(o[0][0]);
        for (int r = 0; r < 4; r++)
            for (int c = 0; c < 4; c++) begin
                pix = dc + o[r][c];
                if (pix < 0)
                    e.clip_lo = 1'b1;
                if (pix > 255)
                    e.clip_hi = 1'b1;
                e.out.recon[r][c] = pixel_t'(clip_pixel(pix));
            end
        e.acc_cycle = cycle;
        return e;
    endfunction

    task automatic check_value(input int cat, input string what,
                               input logic [255:0] got, input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            errs[cat]++;
            $display("** Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic compare_output(input exp_t e);
        check_value(2, "coefficients", out_data.coeff, e.out.coeff);
        check_value(3, "reconstructed pixels", out_data.recon, e.out.recon);
        if (e.flat) begin
            flat_count++;
            for (int r = 0; r < 4; r++)
                for (int c = 0; c < 4; c++)
                    check_value(1, "flat block pixel", out_data.recon[r][c],
                                clip_pixel(int'(e.dc) + int'(e.inv00)));
        end
        if (e.clip_lo)
            clip_lo_count++;
        if (e.clip_hi)
            clip_hi_count++;
        // Valid rose on the edge before the one that samples the transfer.
        if (burst)
            check_value(5, "output valid at least 7 cycles after input",
                        cycles - e.acc_cycle > 7, 1);
    endtask

    always @(posedge clk) begin
        if (!rst)
            cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d blocks still outstanding",
                     cycles, N_TOTAL - received);
            $display("Simulation failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        exp_t e;
        if (rst) begin
            in_valid  <= 1'b0;
            out_ready <= 1'b0;
        end else begin
            if (burst && !in_ready)
                skid_full = 1'b1;
            if (in_valid && in_ready) begin
                e = model_block(in_data, cycles);
                expq.push_back(e);
                case_count[e.dc_case]++;
                if (burst && skid_full)
                    check_value(5, "gap between accepted inputs", cycles - last_acc >= 6, 1);
                last_acc = cycles;
                accepted++;
            end
            if (out_valid && out_ready) begin
                if (expq.size() == 0) begin
                    errs[4]++;
                    $display("Output at %0t ns came with no block outstanding", $time);
                end else begin
                    compare_output(expq.pop_front());
                end
                received++;
            end
            if (!in_valid || in_ready) begin   // Hold valid data until it is taken.
                if (issued < target && (burst || next_rand() % 100 < 70)) begin
                    in_valid <= 1'b1;
                    in_data  <= random_block();
                    issued++;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= burst ? 1'b1 : (next_rand() % 100 < 60);
        end
    end

    initial begin
        int total_err;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        in_data   = '0;
        @(posedge clk);
        @(negedge clk);
        while (rst) begin
            check_value(0, "out_valid in reset", out_valid, 0);
            check_value(0, "in_ready in reset", in_ready, 1);
            @(negedge clk);
        end
        check_value(0, "out_valid after reset", out_valid, 0);
        check_value(0, "in_ready after reset", in_ready, 1);
        $display("Test 1 reset: finished, %0d errors", errs[0]);
        wait (received >= N_RANDOM);
        for (int i = 0; i < 4; i++)
            check_value(1, $sformatf("dc case %0d seen", i), case_count[i] > 0, 1);
        check_value(1, "flat blocks seen", flat_count > 0, 1);
        $display("Test 2 dc prediction: finished, cases %0d/%0d/%0d/%0d, %0d flat, %0d errors",
                 case_count[0], case_count[1], case_count[2], case_count[3],
                 flat_count, errs[1]);
        $display("Test 3 coefficients: finished, %0d errors", errs[2]);
        check_value(3, "block clipped at 0 seen", clip_lo_count > 0, 1);
        check_value(3, "block clipped at 255 seen", clip_hi_count > 0, 1);
        $display("Test 4 reconstruction: finished, %0d clipped at 0, %0d clipped at 255, %0d errors",
                 clip_lo_count, clip_hi_count, errs[3]);
        target = N_TOTAL;
        burst  = 1'b1;
        wait (received >= N_TOTAL);
        @(posedge clk);
        check_value(4, "model queue empty", expq.size(), 0);
        check_value(4, "blocks out equal blocks in", received, accepted);
        $display("Test 5 ordering under back-pressure: finished, %0d errors", errs[4]);
        check_value(5, "input skid filled during burst", skid_full, 1);
        $display("Test 6 back-to-back burst: finished, %0d errors", errs[5]);
        total_err = 0;
        foreach (errs[i])
            total_err += errs[i];
        $display("Checks %0d, errors %0d, blocks in %0d, blocks out %0d",
                 checks, total_err, accepted, received);
        if (total_err == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- project.f
design/intra4x4_pkg.sv
design/stream_skid.sv
design/intra_dc_pred.sv
design/fwd_transform_quant.sv
design/inv_transform_dequant.sv
design/intra_4x4_pe.sv
design/intra_4x4_top.sv
sim/tb_clk_gen.sv
sim/tb_intra_4x4.sv
